/* design/wb_pkg.sv */
package wb_pkg;

    localparam int NUM_SLOTS   = 4;
    localparam int NUM_REGS    = 8;
    localparam int WBAQ_DEPTH  = 4;
    localparam int WBAQ_AW     = $clog2(WBAQ_DEPTH);
    localparam int WBAQ_CW     = $clog2(WBAQ_DEPTH + 1);
    localparam int BUS_TIMEOUT = 15;                 // cycles without ack

    localparam logic [2:0] CS_IDX = 3'd1;            // segment index of CS

    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2
    } size_e;

    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_REG  = 2'd1,
        KIND_SEG  = 2'd2,
        KIND_MEM  = 2'd3
    } slot_kind_e;

    typedef union packed {
        struct packed {
            logic [28:0] pad;
            logic [2:0]  idx;
        } reg_view;
        logic [31:0] addr;                           // byte address for mem slots
    } wb_dest_u;

    typedef struct packed {
        slot_kind_e  kind;
        logic        wb;
        logic [31:0] data;
        wb_dest_u    dest;
    } wb_slot_t;

    typedef struct packed {
        logic                        valid;
        size_e                       size;
        wb_slot_t [NUM_SLOTS-1:0]    slot;
        logic [31:0]                 eip;
        logic                        br_valid;
        logic                        br_taken;
        logic                        br_correct;
        logic [31:0]                 br_fip;
        logic                        far_jump;       // cs:eip taken from slot 0
    } wb_op_t;

    typedef struct packed {
        logic        ld;
        logic        is_seg;
        logic [2:0]  idx;
        size_e       size;
        logic [31:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        size_e       size;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] new_eip;
        logic        is_resteer;
        logic        br_valid;
    } branch_out_t;

endpackage

/* design/writeback_stage.sv */
`timescale 1ns/10ps

module writeback_stage
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_op_t      op,
    input  logic        wbaq_full,
    output reg_write_t  reg_wr [NUM_SLOTS],
    output logic        mem_push,
    output mem_req_t    mem_req,
    output logic        stall,
    output branch_out_t branch_out
);

    logic [NUM_SLOTS-1:0] live;
    logic [NUM_SLOTS-1:0] is_mem;
    logic                 mem_any;
    logic                 go;
    logic                 far_cs;
    logic                 resteer_q;
    logic [31:0]          target;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            live[i]   = op.valid && op.slot[i].wb && (op.slot[i].kind != KIND_NONE);
            is_mem[i] = live[i] && (op.slot[i].kind == KIND_MEM);
        end
        far_cs = op.far_jump && live[0];
        if (far_cs) begin
            is_mem[0] = 1'b0;                        // slot 0 carries cs:eip
        end
    end

    // stall only from the ungated slot decode, no loop through go
    assign mem_any = |is_mem;
    assign stall   = wbaq_full && mem_any;
    assign go      = op.valid && !stall;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            reg_wr[i].ld     = go && live[i] &&
                               (op.slot[i].kind inside {KIND_REG, KIND_SEG});
            reg_wr[i].is_seg = (op.slot[i].kind == KIND_SEG);
            reg_wr[i].idx    = op.slot[i].dest.reg_view.idx;
            reg_wr[i].size   = op.size;
            reg_wr[i].data   = op.slot[i].data;
        end
        if (far_cs) begin
            reg_wr[0].ld     = go;
            reg_wr[0].is_seg = 1'b1;
            reg_wr[0].idx    = CS_IDX;
            reg_wr[0].size   = SZ_WORD;
            reg_wr[0].data   = {16'h0, op.slot[0].data[31:16]};
        end
    end

    // lowest mem slot wins, so walk downward
    always_comb begin
        mem_req = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (is_mem[i]) begin
                mem_req.addr = op.slot[i].dest.addr;
                mem_req.data = op.slot[i].data;
            end
        end
        mem_req.size = op.size;
    end

    assign mem_push = go && mem_any;

    assign target = op.far_jump ? {16'h0, op.slot[0].data[15:0]} : op.br_fip;

    always_comb begin
        branch_out.new_eip    = op.br_taken ? target : op.eip;
        branch_out.br_valid   = go && op.br_valid;
        branch_out.is_resteer = go && !op.br_correct && !resteer_q;  // one per flush
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resteer_q <= 1'b0;
        end else begin
            resteer_q <= branch_out.is_resteer;
        end
    end

endmodule

/* design/arch_reg_file.sv */
`timescale 1ns/10ps

module arch_reg_file
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  reg_write_t  reg_wr [NUM_SLOTS],
    input  logic [2:0]  rd_idx,
    input  logic        rd_seg,
    output logic [31:0] rd_data
);

    logic [31:0] gpr     [NUM_REGS];
    logic [15:0] sreg    [NUM_REGS];
    logic [31:0] gpr_val [NUM_SLOTS];
    logic [15:0] seg_val [NUM_SLOTS];

    function automatic logic [31:0] merge_write(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input size_e       size);
        logic [31:0] res;
        res = old_val;
        case (size)
            SZ_BYTE: res[7:0]  = new_val[7:0];
            SZ_WORD: res[15:0] = new_val[15:0];
            default: res       = new_val;
        endcase
        return res;
    endfunction

    always_comb begin
        logic [31:0] seg_tmp;
        for (int p = 0; p < NUM_SLOTS; p++) begin
            gpr_val[p] = merge_write(gpr[reg_wr[p].idx], reg_wr[p].data, reg_wr[p].size);
            seg_tmp    = merge_write({16'h0, sreg[reg_wr[p].idx]}, reg_wr[p].data,
                                     reg_wr[p].size);
            seg_val[p] = seg_tmp[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                gpr[r]  <= '0;
                sreg[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_SLOTS; p++) begin   // later port overrides
                if (reg_wr[p].ld && !reg_wr[p].is_seg) begin
                    gpr[reg_wr[p].idx] <= gpr_val[p];
                end else if (reg_wr[p].ld) begin
                    sreg[reg_wr[p].idx] <= seg_val[p];
                end
            end
        end
    end

    assign rd_data = rd_seg ? {16'h0, sreg[rd_idx]} : gpr[rd_idx];

endmodule

/* design/mem_write_queue.sv */
`timescale 1ns/10ps

module mem_write_queue
    import wb_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  mem_req_t push_req,
    input  logic     pop,
    output mem_req_t head,
    output logic     empty,
    output logic     full
);

    mem_req_t             entries [WBAQ_DEPTH];
    logic [WBAQ_AW-1:0]   rd_ptr;
    logic [WBAQ_AW-1:0]   wr_ptr;
    logic [WBAQ_CW-1:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign empty   = (count == '0);
    assign full    = (count == WBAQ_CW'(WBAQ_DEPTH));
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);      // pop frees a slot this cycle
    assign wr_ptr  = rd_ptr + count[WBAQ_AW-1:0];    // wraps at depth
    assign head    = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/wb_bus_fsm.sv */
`timescale 1ns/10ps

module wb_bus_fsm
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_req_t    head,
    input  logic        empty,
    input  logic        ack,
    input  logic        expired,
    output logic        pop,
    output logic        cyc,
    output logic        stb,
    output logic        we,
    output logic [31:0] adr,
    output logic [31:0] dat_w,
    output logic [3:0]  sel,
    output logic        bus_err
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_DONE                                      // gap cycle between transfers
    } bus_state_e;

    bus_state_e state;
    bus_state_e state_nxt;
    logic       start;

    function automatic logic [3:0] lane_sel(input logic [1:0] a, input size_e size);
        case (size)
            SZ_BYTE: return 4'b0001 << a;
            SZ_WORD: return a[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    assign start = (state == ST_IDLE) && !empty;
    assign pop   = (state == ST_ACTIVE) && (ack || expired);
    assign cyc   = (state == ST_ACTIVE);
    assign stb   = cyc;
    assign we    = 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (start) state_nxt = ST_ACTIVE;
            ST_ACTIVE: if (pop) state_nxt = ST_DONE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            bus_err <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_ACTIVE && expired && !ack) begin
                bus_err <= 1'b1;                     // sticky until reset
            end
        end
    end

    // narrow data replicated across all lanes, sel picks the live ones
    always_ff @(posedge clk) begin
        if (start) begin
            adr <= head.addr;
            sel <= lane_sel(head.addr[1:0], head.size);
            case (head.size)
                SZ_BYTE: dat_w <= {4{head.data[7:0]}};
                SZ_WORD: dat_w <= {2{head.data[15:0]}};
                default: dat_w <= head.data;
            endcase
        end
    end

endmodule

/* design/bus_timeout_timer.sv */
`timescale 1ns/10ps

module bus_timeout_timer
    import wb_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic ack,
    output logic expired
);

    logic [3:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || ack) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // cnt is 0 in the first cyc cycle, so this fires on cycle BUS_TIMEOUT
    assign expired = run && !ack && (cnt == 4'(BUS_TIMEOUT - 1));

endmodule

/* design/writeback_top.sv */
`timescale 1ns/10ps

module writeback_top
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_op_t      op,
    input  logic [2:0]  rd_idx,
    input  logic        rd_seg,
    input  logic        wb_ack,
    output logic        stall,
    output branch_out_t branch_out,
    output logic [31:0] rd_data,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] wb_dat_w,
    output logic [3:0]  wb_sel,
    output logic        bus_err
);

    reg_write_t reg_wr [NUM_SLOTS];
    logic       mem_push;
    mem_req_t   mem_req;
    mem_req_t   head;
    logic       wbaq_empty;
    logic       wbaq_full;
    logic       wbaq_pop;
    logic       expired;

    writeback_stage u_stage (
        .clk, .rst_n, .op, .wbaq_full, .reg_wr, .mem_push, .mem_req, .stall, .branch_out
    );

    arch_reg_file u_regs (
        .clk, .rst_n, .reg_wr, .rd_idx, .rd_seg, .rd_data
    );

    mem_write_queue u_wbaq (
        .clk, .rst_n, .push(mem_push), .push_req(mem_req), .pop(wbaq_pop),
        .head, .empty(wbaq_empty), .full(wbaq_full)
    );

    wb_bus_fsm u_bus (
        .clk, .rst_n, .head, .empty(wbaq_empty), .ack(wb_ack), .expired,
        .pop(wbaq_pop), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_w(wb_dat_w), .sel(wb_sel), .bus_err
    );

    bus_timeout_timer u_timer (
        .clk, .rst_n, .run(wb_cyc), .ack(wb_ack), .expired
    );

endmodule

/* test/writeback_checker.sv */
`timescale 1ns/10ps

module writeback_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        cyc,
    input logic        stb,
    input logic        ack,
    input logic [31:0] adr,
    input logic [31:0] dat_w,
    input logic [3:0]  sel
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n) stb |-> cyc)
        else $error("stb high while cyc is low");

    // address, data and lanes hold until the slave answers
    hold_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        stb && !ack |=> !stb || ($stable(adr) && $stable(dat_w) && $stable(sel)))
        else $error("bus request changed before ack");

    cyc_drops_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        cyc && ack |=> !cyc)
        else $error("cyc still high in the cycle after ack");

endmodule

bind wb_bus_fsm writeback_checker u_checker (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .ack(ack),
    .adr(adr), .dat_w(dat_w), .sel(sel)
);

/* test/tb_writeback.sv */
`timescale 1ns/10ps

module tb_writeback
    import wb_pkg::*;
();

    localparam int          N_OPS     = 220;
    localparam int          MAX_CYC   = N_OPS * 20 + 500;
    localparam logic [31:0] DEAD_ADDR = 32'hbad0_0000;     // never acked

    logic        clk = 1'b0;
    logic        rst_n;
    wb_op_t      op;
    logic [2:0]  rd_idx;
    logic        rd_seg;
    logic        wb_ack = 1'b0;
    logic        stall, wb_cyc, wb_stb, wb_we, bus_err;
    branch_out_t branch_out;
    logic [31:0] rd_data, wb_adr, wb_dat_w;
    logic [3:0]  wb_sel;

    integer      seed = 32'h969b0a17;
    logic [31:0] m_gpr [NUM_REGS];
    logic [15:0] m_seg [NUM_REGS];
    mem_req_t    exp_q [$];                              // writes not yet seen on the bus
    int          push_cnt = 0;
    int          done_cnt = 0;
    int          errors = 0;
    int          cycles = 0;
    int          stalls = 0;
    int          bus_cyc_len = 0;
    int          wait_left = 0;
    logic        prev_resteer = 1'b0;
    logic        in_xfer = 1'b0;
    logic        slow = 1'b0;

    writeback_top UUT (
        .clk, .rst_n, .op, .rd_idx, .rd_seg, .wb_ack, .stall, .branch_out, .rd_data,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .bus_err
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYC) begin
            $display("run stopped after %0d cycles without finishing", MAX_CYC);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] merged(input logic [31:0] old_val,
                                           input logic [31:0] val, input size_e size);
        if (size == SZ_BYTE) return {old_val[31:8], val[7:0]};
        if (size == SZ_WORD) return {old_val[31:16], val[15:0]};
        return val;
    endfunction

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s exp=%b got=%b", $time, name, exp, got);
        end
    endtask

    task automatic check_branch(input branch_out_t exp);
        if (branch_out !== exp) begin
            errors++;
            $display("MISMATCH t=%0t branch_out exp=%h/%b/%b got=%h/%b/%b", $time,
                     exp.new_eip, exp.is_resteer, exp.br_valid, branch_out.new_eip,
                     branch_out.is_resteer, branch_out.br_valid);
        end
    endtask

    task automatic check_bus(input mem_req_t exp);
        logic [3:0]  e_sel;
        logic [31:0] e_dat;
        logic [31:0] mask;
        for (int l = 0; l < 4; l++) begin               // lane l holds byte address l
            case (exp.size)
                SZ_BYTE: e_sel[l] = (l == exp.addr[1:0]);
                SZ_WORD: e_sel[l] = ((l / 2) == exp.addr[1]);
                default: e_sel[l] = 1'b1;
            endcase
        end
        case (exp.size)
            SZ_BYTE: e_dat = {24'h0, exp.data[7:0]} << {exp.addr[1:0], 3'b000};
            SZ_WORD: e_dat = {16'h0, exp.data[15:0]} << {exp.addr[1], 4'b0000};
            default: e_dat = exp.data;
        endcase
        mask = {{8{e_sel[3]}}, {8{e_sel[2]}}, {8{e_sel[1]}}, {8{e_sel[0]}}};
        if (wb_adr !== exp.addr || wb_sel !== e_sel || (wb_dat_w & mask) !== e_dat
                || wb_we !== 1'b1) begin
            errors++;
            $display("MISMATCH t=%0t wb adr/dat/sel exp=%h/%h/%b got=%h/%h/%b", $time,
                     exp.addr, e_dat, e_sel, wb_adr, wb_dat_w & mask, wb_sel);
        end
    endtask

    // slave with random wait states, answering on the falling edge
    always @(negedge clk) begin
        if (in_xfer && !wb_cyc) begin                   // closed at the last rising edge
            in_xfer = 1'b0;
            wb_ack  = 1'b0;
            done_cnt++;
            check_flag("wb_stb", 1'b0, wb_stb);
        end
        if (wb_cyc === 1'b1 && !in_xfer) begin
            in_xfer     = 1'b1;
            bus_cyc_len = 0;
            wait_left   = slow ? 4 + pick(8) : pick(4);
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected bus write to %h at t=%0t", wb_adr, $time);
            end else begin
                check_bus(exp_q.pop_front());
            end
        end
        if (in_xfer) begin
            check_flag("wb_stb", 1'b1, wb_stb);
            bus_cyc_len++;
            wb_ack = 1'b0;
            if (bus_cyc_len > BUS_TIMEOUT) begin
                errors++;
                $display("bus cycle to %h was not ended by the timeout", wb_adr);
            end else if (wait_left == 0 && wb_adr != DEAD_ADDR) begin
                wb_ack = 1'b1;
            end else if (wait_left > 0) begin
                wait_left--;
            end
        end
    end

    function automatic wb_op_t rand_op(input int test, input logic dead);
        wb_op_t o;
        o            = '0;
        o.valid      = (test != 6) || (pick(2) == 0);
        o.size       = size_e'(2'(pick(3)));
        o.eip        = $random(seed);
        o.br_fip     = $random(seed);
        o.br_correct = 1'b1;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            o.slot[i].kind      = slot_kind_e'(2'(pick(test == 1 ? 3 : 4)));  // no mem in 1
            o.slot[i].wb        = (test != 6 || !o.valid) && (pick(6) != 0);
            o.slot[i].data      = $random(seed);
            o.slot[i].dest.addr = {16'h0010, 16'($random(seed))};
            if (o.slot[i].kind != KIND_MEM) begin
                o.slot[i].dest.reg_view.idx = 3'(pick(NUM_REGS));
            end
        end
        if (test == 4) begin
            o.br_valid   = 1'b1;
            o.br_taken   = (pick(2) == 0);
            o.br_correct = (pick(2) == 0);
            o.far_jump   = (pick(3) == 0);
            if (o.far_jump) begin
                o.br_taken   = 1'b1;
                o.slot[0].wb = 1'b1;
                if (o.slot[0].kind == KIND_NONE) o.slot[0].kind = KIND_MEM;
            end
        end
        if (dead) begin
            o.slot[0].kind      = KIND_MEM;
            o.slot[0].wb        = 1'b1;
            o.slot[0].dest.addr = DEAD_ADDR;
        end
        return o;
    endfunction

    // holds one op until it is taken, then updates the model
    task automatic run_op(input wb_op_t nop, input logic [3:0] rd_sel);
        logic [NUM_SLOTS-1:0] live;
        logic                 far_cs;
        logic                 mem_any;
        logic                 stall_exp;
        logic                 go;
        logic [2:0]           ix;
        logic [31:0]          tmp;
        logic [31:0]          g_old [NUM_REGS];
        logic [15:0]          s_old [NUM_REGS];
        mem_req_t             req;
        branch_out_t          bexp;
        stall_exp = 1'b1;
        while (stall_exp) begin
            @(negedge clk);
            op     = nop;
            rd_idx = rd_sel[2:0];
            rd_seg = rd_sel[3];
            #1;
            check_reg("rd_data", rd_seg ? {16'h0, m_seg[rd_idx]} : m_gpr[rd_idx], rd_data);
            for (int i = 0; i < NUM_SLOTS; i++) begin
                live[i] = nop.valid && nop.slot[i].wb && (nop.slot[i].kind != KIND_NONE);
            end
            far_cs  = nop.far_jump && live[0];
            mem_any = 1'b0;
            req     = '0;
            for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
                if (live[i] && nop.slot[i].kind == KIND_MEM && !(i == 0 && far_cs)) begin
                    mem_any  = 1'b1;
                    req.addr = nop.slot[i].dest.addr;
                    req.data = nop.slot[i].data;
                end
            end
            req.size        = nop.size;
            stall_exp       = mem_any && (push_cnt - done_cnt == WBAQ_DEPTH);
            go              = nop.valid && !stall_exp;
            bexp.new_eip    = !nop.br_taken ? nop.eip :
                              nop.far_jump ? {16'h0, nop.slot[0].data[15:0]} : nop.br_fip;
            bexp.is_resteer = go && !nop.br_correct && !prev_resteer;
            bexp.br_valid   = go && nop.br_valid;
            check_flag("stall", stall_exp, stall);
            check_branch(bexp);
            prev_resteer = bexp.is_resteer;
            if (stall_exp) stalls++;
            if (go) begin
                g_old = m_gpr;
                s_old = m_seg;
                for (int i = 0; i < NUM_SLOTS; i++) begin  // higher slot wins
                    ix = nop.slot[i].dest.reg_view.idx;
                    if (i == 0 && far_cs) begin
                        m_seg[CS_IDX] = nop.slot[0].data[31:16];
                    end else if (live[i] && nop.slot[i].kind == KIND_REG) begin
                        m_gpr[ix] = merged(g_old[ix], nop.slot[i].data, nop.size);
                    end else if (live[i] && nop.slot[i].kind == KIND_SEG) begin
                        tmp       = merged({16'h0, s_old[ix]}, nop.slot[i].data, nop.size);
                        m_seg[ix] = tmp[15:0];
                    end
                end
                if (mem_any) begin
                    exp_q.push_back(req);
                    push_cnt++;
                end
            end
        end
    endtask

    task automatic run_test(input int test, input string name, input int n_ops);
        wb_op_t idle;
        int     err0;
        int     stall0;
        idle   = '0;
        err0   = errors;
        stall0 = stalls;
        slow   = (test == 3);
        for (int k = 0; k < n_ops; k++) begin
            run_op(rand_op(test, test == 5 && k == 0), 4'($random(seed)));
        end
        while (push_cnt != done_cnt) begin                // let the queue drain
            run_op(idle, 4'($random(seed)));
        end
        for (int r = 0; r < 2 * NUM_REGS; r++) begin
            run_op(idle, 4'(r));
        end
        check_flag("bus_err", test >= 5, bus_err);
        if (test == 3 && stalls == stall0) begin
            errors++;
            $display("stall never rose although the responder was slowed");
        end
        $display("test %0d %s: %0d ops, %0d errors", test, name, n_ops, errors - err0);
    endtask

    initial begin
        rst_n  = 1'b0;
        op     = '0;
        rd_idx = '0;
        rd_seg = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            m_gpr[r] = '0;
            m_seg[r] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        check_flag("wb_cyc", 1'b0, wb_cyc);
        run_test(1, "register writes", 60);
        run_test(2, "memory writes", 40);
        run_test(3, "back-pressure", 40);
        run_test(4, "branches", 40);
        run_test(5, "bus timeout", 10);
        run_test(6, "inactive ops", 30);
        $display("6 tests, %0d ops, %0d stalls, %0d errors", N_OPS, stalls, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
design/wb_pkg.sv
design/writeback_stage.sv
design/arch_reg_file.sv
design/mem_write_queue.sv
design/wb_bus_fsm.sv
design/bus_timeout_timer.sv
design/writeback_top.sv
test/writeback_checker.sv
test/tb_writeback.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the run from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_writeback -o tb_sim &&
    ./obj_dir/tb_sim > sim.log 2>&1 || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log && ! grep -q "TESTBENCH FAILED" sim.log && exit 0 || exit 1
